// File: verilog/cpu_pkg.sv
package cpu_pkg;

    // machine widths
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;

    // fetch buffer sizing
    localparam int FETCH_DEPTH = 4;
    localparam int FETCH_PTR_W = $clog2(FETCH_DEPTH);

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // opcode field widths of the two formats
    localparam int OPC_3R_W    = 17;
    localparam int OPC_RI12_W  = 10;
    localparam int IMM12_W     = 12;

    // three-register major opcodes, bits 31..15
    localparam logic [OPC_3R_W-1:0] OP_ADD_W = 17'h00020;
    localparam logic [OPC_3R_W-1:0] OP_SUB_W = 17'h00022;
    localparam logic [OPC_3R_W-1:0] OP_AND   = 17'h00029;
    localparam logic [OPC_3R_W-1:0] OP_OR    = 17'h0002a;
    localparam logic [OPC_3R_W-1:0] OP_XOR   = 17'h0002b;

    // 12-bit immediate opcodes, bits 31..22
    localparam logic [OPC_RI12_W-1:0] OP_ADDI_W = 10'h00a;
    localparam logic [OPC_RI12_W-1:0] OP_ANDI   = 10'h00d;
    localparam logic [OPC_RI12_W-1:0] OP_ORI    = 10'h00e;

    typedef struct packed {
        logic [OPC_3R_W-1:0]   opcode;
        logic [REG_ADDR_W-1:0] rk;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [OPC_RI12_W-1:0] opcode;
        logic [IMM12_W-1:0]    imm;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } fmt_2ri12_t;

    // one instruction word, seen as either format
    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        instr_u          instr;
    } fetch_entry_t;

    // master side of the wishbone read bus
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic [XLEN-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rk;
        logic [XLEN-1:0]       imm;
        logic                  use_imm;
        logic                  we;
    } uop_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic [XLEN-1:0]       data;
    } retire_t;

endpackage

// File: verilog/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    output wb_req_t         wb_req,
    input  logic            wb_ack,
    input  logic [XLEN-1:0] wb_dat,
    input  logic            full,
    output logic            push,
    output fetch_entry_t    entry
);

    logic [XLEN-1:0] pc_q;
    // a read is open on the bus
    logic            busy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q   <= RESET_PC;
            busy_q <= 1'b0;
        end else if (busy_q) begin
            if (wb_ack) begin
                pc_q <= pc_q + XLEN'(4);
                // chain straight into the next read when there is room
                busy_q <= !full;
            end
        end else begin
            busy_q <= !full;
        end
    end

    assign wb_req = '{cyc: busy_q, stb: busy_q, adr: pc_q};

    // ack closes the read and hands the word to the buffer
    assign push  = busy_q && wb_ack;
    assign entry = '{pc: pc_q, instr: instr_u'(wb_dat)};

    // address and strobe held until the slave answers
    adr_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb && !wb_ack |=> wb_req.stb && $stable(wb_req.adr));

endmodule

// File: verilog/fetch_buffer.sv
`timescale 1ns/1ns

module fetch_buffer import cpu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         push,
    input  fetch_entry_t push_entry,
    output logic         full,
    input  logic         pop,
    output fetch_entry_t head,
    output logic         empty
);

    fetch_entry_t           mem [FETCH_DEPTH];
    logic [FETCH_PTR_W-1:0] wr_ptr;
    logic [FETCH_PTR_W-1:0] rd_ptr;
    logic [FETCH_PTR_W:0]   count;

    function automatic logic [FETCH_PTR_W-1:0] ptr_next(input logic [FETCH_PTR_W-1:0] ptr);
        logic [FETCH_PTR_W-1:0] nxt;
        if (ptr == FETCH_PTR_W'(FETCH_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign full  = (count == (FETCH_PTR_W + 1)'(FETCH_DEPTH));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // fetch side must respect full
    no_overflow_a: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full);

    // consumer pops only real entries
    no_underflow_a: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

// File: verilog/decoder.sv
`timescale 1ns/1ns

module decoder import cpu_pkg::*; (
    input  instr_u          instr,
    input  logic [XLEN-1:0] pc,
    output uop_t            uop
);

    logic known;

    always_comb begin
        uop        = '0;
        uop.pc     = pc;
        uop.alu_op = ALU_ADD;
        // register fields sit at the same bits in both formats
        uop.rd     = instr.r3.rd;
        uop.rj     = instr.r3.rj;
        uop.rk     = instr.r3.rk;
        known      = 1'b1;

        case (instr.r3.opcode)
            OP_ADD_W: uop.alu_op = ALU_ADD;
            OP_SUB_W: uop.alu_op = ALU_SUB;
            OP_AND:   uop.alu_op = ALU_AND;
            OP_OR:    uop.alu_op = ALU_OR;
            OP_XOR:   uop.alu_op = ALU_XOR;
            default: begin
                uop.use_imm = 1'b1;
                case (instr.ri12.opcode)
                    OP_ADDI_W: begin
                        uop.alu_op = ALU_ADD;
                        uop.imm = {{(XLEN - IMM12_W){instr.ri12.imm[IMM12_W-1]}},
                                   instr.ri12.imm};
                    end
                    OP_ANDI: begin
                        // logical immediates are zero extended
                        uop.alu_op = ALU_AND;
                        uop.imm    = {{(XLEN - IMM12_W){1'b0}}, instr.ri12.imm};
                    end
                    OP_ORI: begin
                        uop.alu_op = ALU_OR;
                        uop.imm    = {{(XLEN - IMM12_W){1'b0}}, instr.ri12.imm};
                    end
                    default: begin
                        // unknown word, retires without a write
                        uop.use_imm = 1'b0;
                        known       = 1'b0;
                    end
                endcase
            end
        endcase

        uop.we = known && (instr.r3.rd != '0);
    end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ns

module register_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] rd_idx_a,
    input  logic [REG_ADDR_W-1:0] rd_idx_b,
    output logic [XLEN-1:0]       rd_data_a,
    output logic [XLEN-1:0]       rd_data_b,
    input  logic                  wr_en,
    input  logic [REG_ADDR_W-1:0] wr_idx,
    input  logic [XLEN-1:0]       wr_data
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // r0 is hardwired, a same-cycle write is passed straight through
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] idx);
        logic [XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (wr_en && (wr_idx == idx)) begin
            val = wr_data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_idx_a);
        rd_data_b = read_port(rd_idx_b);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

// File: verilog/exec_pipeline.sv
`timescale 1ns/1ns

module exec_pipeline import cpu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         empty,
    input  fetch_entry_t head,
    output logic         pop,
    output retire_t      retire
);

    uop_t            dec_uop;
    logic [XLEN-1:0] rf_a;
    logic [XLEN-1:0] rf_b;

    // decode/read stage register
    logic            ex_valid;
    uop_t            ex_uop;
    logic [XLEN-1:0] ex_a;
    logic [XLEN-1:0] ex_b;

    logic            ret_wr;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;

    // never stalls, take whatever the buffer holds
    assign pop = !empty;

    decoder decoder_i (
        .instr (head.instr),
        .pc    (head.pc),
        .uop   (dec_uop)
    );

    assign ret_wr = retire.valid && retire.we;

    register_file register_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_idx_a  (dec_uop.rj),
        .rd_idx_b  (dec_uop.rk),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b),
        .wr_en     (ret_wr),
        .wr_idx    (retire.rd),
        .wr_data   (retire.data)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            ex_uop <= dec_uop;
            ex_a   <= rf_a;
            ex_b   <= rf_b;
        end
    end

    // forward from the instruction retiring right now
    always_comb begin
        src_a = ex_a;
        src_b = ex_b;
        if (ret_wr && (retire.rd == ex_uop.rj)) begin
            src_a = retire.data;
        end
        if (ret_wr && (retire.rd == ex_uop.rk)) begin
            src_b = retire.data;
        end
        op_b = ex_uop.use_imm ? ex_uop.imm : src_b;

        case (ex_uop.alu_op)
            ALU_ADD: alu_out = src_a + op_b;
            ALU_SUB: alu_out = src_a - op_b;
            ALU_AND: alu_out = src_a & op_b;
            ALU_OR:  alu_out = src_a | op_b;
            ALU_XOR: alu_out = src_a ^ op_b;
            default: alu_out = src_a + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire <= '0;
        end else begin
            retire.valid <= ex_valid;
            retire.pc    <= ex_uop.pc;
            retire.rd    <= ex_uop.rd;
            retire.we    <= ex_uop.we;
            retire.data  <= alu_out;
        end
    end

    // decoder drops rd zero writes before they reach the write port
    no_r0_write_a: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && retire.we |-> retire.rd != '0);

endmodule

// File: verilog/cpu_core.sv
`timescale 1ns/1ns

module cpu_core import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    output wb_req_t         wb_req,
    input  logic            wb_ack,
    input  logic [XLEN-1:0] wb_dat,
    output retire_t         retire
);

    logic         buf_push;
    fetch_entry_t buf_in;
    logic         buf_full;
    logic         buf_pop;
    fetch_entry_t buf_head;
    logic         buf_empty;

    fetch_unit fetch_unit_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_ack (wb_ack),
        .wb_dat (wb_dat),
        .full   (buf_full),
        .push   (buf_push),
        .entry  (buf_in)
    );

    fetch_buffer fetch_buffer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (buf_push),
        .push_entry (buf_in),
        .full       (buf_full),
        .pop        (buf_pop),
        .head       (buf_head),
        .empty      (buf_empty)
    );

    exec_pipeline exec_pipeline_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .empty  (buf_empty),
        .head   (buf_head),
        .pop    (buf_pop),
        .retire (retire)
    );

endmodule

// File: dv/tb_cpu_core.sv
`timescale 1ns/1ns

module tb_cpu_core import cpu_pkg::*; ();

    localparam int PROG_WORDS  = 64;
    localparam int CYCLE_LIMIT = PROG_WORDS * 8 + 100;

    typedef logic [XLEN-1:0] reg_array_t [NUM_REGS];

    logic            clk;
    logic            rst_n;
    wb_req_t         wb_req;
    logic            wb_ack;
    logic [XLEN-1:0] wb_dat;
    retire_t         retire;

    logic [XLEN-1:0] prog_mem [PROG_WORDS];
    reg_array_t      model_regs;
    logic [31:0]     lcg_state = 32'h69cf_d784;
    logic [31:0]     delay_rnd;
    logic [1:0]      wait_cnt;
    logic [XLEN-1:0] exp_pc = RESET_PC;
    logic [XLEN-1:0] exp_adr = RESET_PC;
    retire_t         rt_exp;
    int              retired = 0;
    int              cycles = 0;
    int              mismatch_count = 0;
    int              timeout_count = 0;

    cpu_core cpu_core_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_ack (wb_ack),
        .wb_dat (wb_dat),
        .retire (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // words past the end of the program read as zero
    function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] adr);
        if (adr < 32'd256) begin
            return prog_mem[adr[7:2]];
        end
        return '0;
    endfunction

    // expected retire record, straight from the instruction encoding
    function automatic retire_t ref_retire(input logic [31:0] word, input logic [31:0] pc,
                                           inout reg_array_t regs);
        retire_t     exp;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_s;
        logic [31:0] imm_z;
        logic [31:0] res;
        logic        known;
        a     = (word[9:5] == 5'd0) ? 32'd0 : regs[word[9:5]];
        b     = (word[14:10] == 5'd0) ? 32'd0 : regs[word[14:10]];
        imm_s = {{20{word[21]}}, word[21:10]};
        imm_z = {20'd0, word[21:10]};
        known = 1'b1;
        res   = 32'd0;
        case (word[31:15])
            OP_ADD_W: res = a + b;
            OP_SUB_W: res = a - b;
            OP_AND:   res = a & b;
            OP_OR:    res = a | b;
            OP_XOR:   res = a ^ b;
            default: begin
                case (word[31:22])
                    OP_ADDI_W: res = a + imm_s;
                    OP_ANDI:   res = a & imm_z;
                    OP_ORI:    res = a | imm_z;
                    default:   known = 1'b0;
                endcase
            end
        endcase
        exp.valid = 1'b1;
        exp.pc    = pc;
        exp.rd    = word[4:0];
        exp.we    = known && (word[4:0] != 5'd0);
        exp.data  = res;
        if (exp.we) begin
            regs[word[4:0]] = res;
        end
        return exp;
    endfunction

    task automatic build_program();
        logic [31:0] rnd;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [4:0]  prev_rd;
        logic [4:0]  prev2_rd;
        logic [16:0] op17;
        logic [9:0]  op10;
        int          kind;
        prev_rd  = 5'd0;
        prev2_rd = 5'd0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            rnd  = lcg_next();
            // r0..r7 only, so reuse is frequent
            rd   = {2'b00, rnd[2:0]};
            rj   = {2'b00, rnd[5:3]};
            rk   = {2'b00, rnd[8:6]};
            kind = rnd[19:16] % 10;
            // planned hazards on the last two results
            if (i % 4 == 1) rj = prev_rd;
            if (i % 5 == 2) rk = prev2_rd;
            if (i % 9 == 4) rd = 5'd0;
            // seed r1..r6 with addi.w first
            if (i < 6) begin
                kind = 5;
                rd   = 5'(i + 1);
                rj   = 5'd0;
            end
            case (kind)
                0:       op17 = OP_ADD_W;
                1:       op17 = OP_SUB_W;
                2:       op17 = OP_AND;
                3:       op17 = OP_OR;
                default: op17 = OP_XOR;
            endcase
            case (kind)
                5:       op10 = OP_ADDI_W;
                6:       op10 = OP_ANDI;
                default: op10 = OP_ORI;
            endcase
            if (kind < 5) begin
                prog_mem[i] = {op17, rk, rj, rd};
            end else if (kind < 8) begin
                prog_mem[i] = {op10, rnd[31:20], rj, rd};
            end else begin
                // undefined opcode
                prog_mem[i] = {10'h3ff, rnd[21:10], rj, rd};
            end
            prev2_rd = prev_rd;
            prev_rd  = rd;
        end
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp);
        if (got.pc !== exp.pc) begin
            $display("mismatch retire.pc got %h expected %h", got.pc, exp.pc);
            mismatch_count++;
        end
        if (got.rd !== exp.rd) begin
            $display("mismatch retire.rd got %h expected %h", got.rd, exp.rd);
            mismatch_count++;
        end
        if (got.we !== exp.we) begin
            $display("mismatch retire.we got %h expected %h at pc %h", got.we, exp.we, exp.pc);
            mismatch_count++;
        end
        if (exp.we && (got.data !== exp.data)) begin
            $display("mismatch retire.data got %h expected %h at pc %h",
                     got.data, exp.data, exp.pc);
            mismatch_count++;
        end
    endtask

    task automatic check_adr(input wb_req_t got, input logic [XLEN-1:0] exp);
        // cyc frames every strobe and drops together with it
        if (got.cyc !== got.stb) begin
            $display("mismatch wb_req.cyc got %h expected %h", got.cyc, got.stb);
            mismatch_count++;
        end
        if (got.stb && (got.adr !== exp)) begin
            $display("mismatch wb_req.adr got %h expected %h", got.adr, exp);
            mismatch_count++;
        end
    endtask

    // wishbone slave, one-cycle ack after a random wait
    always @(posedge clk) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (wb_ack) begin
            wb_ack    <= 1'b0;
            delay_rnd  = lcg_next();
            wait_cnt  <= delay_rnd[17:16];
        end else if (wb_req.stb) begin
            if (wait_cnt == 2'd0) begin
                wb_ack <= 1'b1;
                wb_dat <= mem_word(wb_req.adr);
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && retire.valid) begin
            rt_exp = ref_retire(mem_word(exp_pc), exp_pc, model_regs);
            check_retire(retire, rt_exp);
            exp_pc = exp_pc + 32'd4;
            retired++;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            check_adr(wb_req, exp_adr);
            if (wb_req.stb && wb_ack) begin
                exp_adr = exp_adr + 32'd4;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
    end

    initial begin
        rst_n  = 1'b0;
        wb_ack = 1'b0;
        wb_dat = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        build_program();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        while (retired < PROG_WORDS && cycles < CYCLE_LIMIT) begin
            @(negedge clk);
        end
        if (retired < PROG_WORDS) begin
            $display("timeout after %0d cycles, only %0d of %0d instructions retired",
                     cycles, retired, PROG_WORDS);
            timeout_count++;
        end
        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
verilog/cpu_pkg.sv
verilog/fetch_unit.sv
verilog/fetch_buffer.sv
verilog/decoder.sv
verilog/register_file.sv
verilog/exec_pipeline.sv
verilog/cpu_core.sv
dv/tb_cpu_core.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -sv -f tb.f --top-module tb_cpu_core \
		-Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
